// ==== include/cpu_macros.svh ====
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

`define CPU_XLEN      32             // data and address width.
`define CPU_NREGS     16
`define CPU_RIDX_W    4              // register index width.
`define CPU_RESET_PC  32'h0000_0000

`endif

// ==== list.f ====
+incdir+include
rtl/cpu_pkg.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/rbank.sv
rtl/alu_stage.sv
rtl/mem_stage.sv
rtl/cpu.sv
verif/cpu_properties.sv
verif/cpu_tb.sv

// ==== rtl/alu_stage.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module alu_stage
  import cpu_pkg::*;
(
  input  wire             clk_i,
  input  wire             rst_i,
  input  wire             stall_i,
  input  wire dec_exe_t   exe_i,
  output redirect_t       redir_o,
  output exe_mem_t        mem_o
);

  logic [`CPU_XLEN-1:0]    result;
  logic [`CPU_XLEN-1:0]    target;
  logic                    taken;

  // execute/memory register.
  logic                    valid_q;
  logic [`CPU_XLEN-1:0]    pc_q;
  opcode_e                 op_q;
  logic [`CPU_RIDX_W-1:0]  rd_q;
  logic [`CPU_XLEN-1:0]    res_q;
  logic [`CPU_XLEN-1:0]    sdata_q;
  logic                    wr_q;

  assign target = exe_i.pc + (exe_i.imm << 2);  // word offset.

  always_comb begin
    result = '0;
    taken  = 1'b0;
    case (exe_i.op)
      OP_ADD:  result = exe_i.rs1_val + exe_i.rs2_val;
      OP_SUB:  result = exe_i.rs1_val - exe_i.rs2_val;
      OP_AND:  result = exe_i.rs1_val & exe_i.rs2_val;
      OP_OR:   result = exe_i.rs1_val | exe_i.rs2_val;
      OP_XOR:  result = exe_i.rs1_val ^ exe_i.rs2_val;
      OP_ADDI, OP_LW, OP_SW: begin
        result = exe_i.rs1_val + exe_i.imm;
      end
      OP_BEQ:  taken = (exe_i.rs1_val == exe_i.rs2_val);
      OP_BNE:  taken = (exe_i.rs1_val != exe_i.rs2_val);
      OP_JAL: begin
        result = exe_i.pc + `CPU_XLEN'(4);  // link value.
        taken  = 1'b1;
      end
      default: result = '0;
    endcase
  end

  // fire once, on the edge the branch moves on.
  assign redir_o = '{taken: exe_i.valid & taken & ~stall_i, target: target};

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      valid_q <= 1'b0;
    end else if (!stall_i) begin
      valid_q <= exe_i.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!stall_i) begin
      pc_q    <= exe_i.pc;
      op_q    <= exe_i.op;
      rd_q    <= exe_i.rd;
      res_q   <= result;
      sdata_q <= exe_i.rs2_val;
      wr_q    <= op_writes_rd(exe_i.op);
    end
  end

  assign mem_o = '{valid:  valid_q,
                   pc:     pc_q,
                   op:     op_q,
                   rd:     rd_q,
                   result: res_q,
                   sdata:  sdata_q,
                   wr_en:  wr_q};

endmodule

`default_nettype wire

// ==== rtl/cpu.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module cpu
  import cpu_pkg::*;
(
  input  wire                  clk_i,
  input  wire                  rst_i,
  output mem_req_t             mem_req_o,
  input  wire                  mem_valid_i,
  input  wire [`CPU_XLEN-1:0]  mem_rdata_i,
  output retire_t              retire_o
);

  mem_req_t                f_req;
  mem_req_t                m_req;
  logic                    mem_gnt;
  logic                    busy_q;       // a transfer is on the port.
  logic                    owner_mem_q;

  logic                    dec_valid;
  logic [`CPU_XLEN-1:0]    dec_pc;
  instr_t                  dec_instr;
  logic [`CPU_RIDX_W-1:0]  rs1;
  logic [`CPU_RIDX_W-1:0]  rs2;
  logic [`CPU_XLEN-1:0]    rs1_data;
  logic [`CPU_XLEN-1:0]    rs2_data;
  dec_exe_t                dec_exe;
  logic                    hazard;
  redirect_t               redir;
  exe_mem_t                exe_mem;
  logic                    stall;
  logic                    wb_en;
  logic [`CPU_RIDX_W-1:0]  wb_reg;
  logic [`CPU_XLEN-1:0]    wb_data;

  // data side first, but an open transfer keeps its owner.
  assign mem_gnt   = busy_q ? owner_mem_q : (m_req.rd | m_req.wr);
  assign mem_req_o = mem_gnt ? m_req : f_req;

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      busy_q      <= 1'b0;
      owner_mem_q <= 1'b0;
    end else begin
      busy_q      <= (mem_req_o.rd | mem_req_o.wr) & ~mem_valid_i;
      owner_mem_q <= mem_gnt;
    end
  end

  fetch_stage u_fetch (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .stall_i     (stall),
    .hazard_i    (hazard),
    .redir_i     (redir),
    .grant_i     (~mem_gnt),
    .rsp_valid_i (mem_valid_i),
    .rdata_i     (mem_rdata_i),
    .req_o       (f_req),
    .dec_valid_o (dec_valid),
    .dec_pc_o    (dec_pc),
    .dec_instr_o (dec_instr)
  );

  decode_stage u_decode (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .valid_i    (dec_valid),
    .pc_i       (dec_pc),
    .instr_i    (dec_instr),
    .stall_i    (stall),
    .redir_i    (redir),
    .rs1_data_i (rs1_data),
    .rs2_data_i (rs2_data),
    .rs1_o      (rs1),
    .rs2_o      (rs2),
    .exe_o      (dec_exe),
    .hazard_o   (hazard)
  );

  rbank u_rbank (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .wr_en_i   (wb_en),
    .wr_reg_i  (wb_reg),
    .wr_data_i (wb_data),
    .rd_a_i    (rs1),
    .rd_b_i    (rs2),
    .a_data_o  (rs1_data),
    .b_data_o  (rs2_data)
  );

  alu_stage u_alu (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .stall_i (stall),
    .exe_i   (dec_exe),
    .redir_o (redir),
    .mem_o   (exe_mem)
  );

  mem_stage u_mem (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .mem_i       (exe_mem),
    .grant_i     (mem_gnt),
    .rsp_valid_i (mem_valid_i),
    .rdata_i     (mem_rdata_i),
    .req_o       (m_req),
    .stall_o     (stall),
    .wb_en_o     (wb_en),
    .wb_reg_o    (wb_reg),
    .wb_data_o   (wb_data),
    .retire_o    (retire_o)
  );

endmodule

`default_nettype wire

// ==== rtl/cpu_pkg.sv ====
`default_nettype none
`include "cpu_macros.svh"

package cpu_pkg;

  typedef enum logic [5:0] {
    OP_NOP  = 6'h00,
    OP_ADD  = 6'h01,
    OP_SUB  = 6'h02,
    OP_AND  = 6'h03,
    OP_OR   = 6'h04,
    OP_XOR  = 6'h05,
    OP_ADDI = 6'h06,
    OP_LW   = 6'h07,
    OP_SW   = 6'h08,
    OP_BEQ  = 6'h09,
    OP_BNE  = 6'h0a,
    OP_JAL  = 6'h0b
  } opcode_e;

  // branch and jal offsets count words.
  typedef struct packed {
    opcode_e                 op;
    logic [`CPU_RIDX_W-1:0]  rd;
    logic [`CPU_RIDX_W-1:0]  rs1;
    logic [`CPU_RIDX_W-1:0]  rs2;
    logic [13:0]             imm;
  } instr_t;

  typedef struct packed {
    logic                    valid;
    logic [`CPU_XLEN-1:0]    pc;
    opcode_e                 op;
    logic [`CPU_RIDX_W-1:0]  rd;
    logic [`CPU_XLEN-1:0]    rs1_val;
    logic [`CPU_XLEN-1:0]    rs2_val;
    logic [`CPU_XLEN-1:0]    imm;     // sign extended.
  } dec_exe_t;

  typedef struct packed {
    logic                    valid;
    logic [`CPU_XLEN-1:0]    pc;
    opcode_e                 op;
    logic [`CPU_RIDX_W-1:0]  rd;
    logic [`CPU_XLEN-1:0]    result;  // alu result or load/store address.
    logic [`CPU_XLEN-1:0]    sdata;
    logic                    wr_en;
  } exe_mem_t;

  typedef struct packed {
    logic                    rd;
    logic                    wr;
    logic                    is_instr;
    logic [`CPU_XLEN-1:0]    addr;
    logic [`CPU_XLEN-1:0]    wdata;
  } mem_req_t;

  typedef struct packed {
    logic                    valid;
    logic [`CPU_XLEN-1:0]    pc;
    logic [`CPU_RIDX_W-1:0]  rd;
    logic                    wr_en;
    logic [`CPU_XLEN-1:0]    data;
  } retire_t;

  typedef struct packed {
    logic                    taken;
    logic [`CPU_XLEN-1:0]    target;
  } redirect_t;

  function automatic logic op_writes_rd(input opcode_e op);
    return op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ADDI, OP_LW, OP_JAL};
  endfunction

endpackage

`default_nettype wire

// ==== rtl/decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module decode_stage
  import cpu_pkg::*;
(
  input  wire                     clk_i,
  input  wire                     rst_i,
  input  wire                     valid_i,
  input  wire [`CPU_XLEN-1:0]     pc_i,
  input  wire instr_t             instr_i,
  input  wire                     stall_i,
  input  wire redirect_t          redir_i,
  input  wire [`CPU_XLEN-1:0]     rs1_data_i,
  input  wire [`CPU_XLEN-1:0]     rs2_data_i,
  output logic [`CPU_RIDX_W-1:0]  rs1_o,
  output logic [`CPU_RIDX_W-1:0]  rs2_o,
  output dec_exe_t                exe_o,
  output logic                    hazard_o
);

  // decode/execute register.
  logic                    exe_valid_q;
  logic [`CPU_XLEN-1:0]    pc_q;
  opcode_e                 op_q;
  logic [`CPU_RIDX_W-1:0]  rd_q;
  logic [`CPU_XLEN-1:0]    a_q;
  logic [`CPU_XLEN-1:0]    b_q;
  logic [`CPU_XLEN-1:0]    imm_q;

  // shadow of the destination now in the memory stage.
  logic                    mem_pend_q;
  logic [`CPU_RIDX_W-1:0]  mem_rd_q;

  logic [`CPU_XLEN-1:0]    imm_ext;
  logic                    exe_pend;
  logic                    use_rs1;
  logic                    use_rs2;
  logic                    busy_rs1;
  logic                    busy_rs2;

  assign rs1_o    = instr_i.rs1;
  assign rs2_o    = instr_i.rs2;
  assign imm_ext  = `CPU_XLEN'(signed'(instr_i.imm));
  assign exe_pend = exe_valid_q & op_writes_rd(op_q) & (rd_q != '0);

  always_comb begin
    use_rs1  = !(instr_i.op inside {OP_NOP, OP_JAL});
    use_rs2  = instr_i.op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
                                  OP_SW, OP_BEQ, OP_BNE};
    busy_rs1 = (exe_pend && instr_i.rs1 == rd_q) || (mem_pend_q && instr_i.rs1 == mem_rd_q);
    busy_rs2 = (exe_pend && instr_i.rs2 == rd_q) || (mem_pend_q && instr_i.rs2 == mem_rd_q);
    hazard_o = valid_i & ((use_rs1 & busy_rs1) | (use_rs2 & busy_rs2));
  end

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      exe_valid_q <= 1'b0;
      mem_pend_q  <= 1'b0;
    end else if (!stall_i) begin
      exe_valid_q <= valid_i & ~hazard_o & ~redir_i.taken;  // bubble on hazard or flush.
      mem_pend_q  <= exe_pend;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!stall_i) begin
      pc_q     <= pc_i;
      op_q     <= instr_i.op;
      rd_q     <= instr_i.rd;
      a_q      <= rs1_data_i;
      b_q      <= rs2_data_i;
      imm_q    <= imm_ext;
      mem_rd_q <= rd_q;
    end
  end

  assign exe_o = '{valid:   exe_valid_q,
                   pc:      pc_q,
                   op:      op_q,
                   rd:      rd_q,
                   rs1_val: a_q,
                   rs2_val: b_q,
                   imm:     imm_q};

endmodule

`default_nettype wire

// ==== rtl/fetch_stage.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module fetch_stage
  import cpu_pkg::*;
(
  input  wire                   clk_i,
  input  wire                   rst_i,
  input  wire                   stall_i,
  input  wire                   hazard_i,
  input  wire redirect_t        redir_i,
  input  wire                   grant_i,
  input  wire                   rsp_valid_i,
  input  wire instr_t           rdata_i,
  output mem_req_t              req_o,
  output logic                  dec_valid_o,
  output logic [`CPU_XLEN-1:0]  dec_pc_o,
  output instr_t                dec_instr_o
);

  logic                  run_q;
  logic                  wait_q;     // request on the port, response still due.
  logic                  discard_q;  // in-flight word is from a flushed path.
  logic [`CPU_XLEN-1:0]  pc_q;
  logic [`CPU_XLEN-1:0]  faddr_q;
  logic                  dec_valid_q;
  logic [`CPU_XLEN-1:0]  dec_pc_q;
  instr_t                dec_instr_q;

  logic                  consume;
  logic                  issue;
  logic                  fetch_rd;
  logic [`CPU_XLEN-1:0]  fetch_addr;
  logic                  on_bus;
  logic                  done;
  logic                  keep;

  assign consume    = dec_valid_q & ~stall_i & ~hazard_i;
  // only start a fetch when the word will have somewhere to go.
  assign issue      = run_q & ~wait_q & (~dec_valid_q | consume) & ~redir_i.taken;
  assign fetch_rd   = wait_q | issue;
  assign fetch_addr = wait_q ? faddr_q : pc_q;
  assign on_bus     = fetch_rd & grant_i;
  assign done       = on_bus & rsp_valid_i;
  assign keep       = done & ~discard_q & ~redir_i.taken;

  assign req_o = '{rd: fetch_rd, wr: 1'b0, is_instr: 1'b1, addr: fetch_addr, wdata: '0};

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      run_q       <= 1'b0;
      wait_q      <= 1'b0;
      discard_q   <= 1'b0;
      pc_q        <= `CPU_RESET_PC;
      dec_valid_q <= 1'b0;
    end else begin
      run_q     <= 1'b1;
      wait_q    <= on_bus & ~rsp_valid_i;
      discard_q <= wait_q & ~done & (discard_q | redir_i.taken);
      if (redir_i.taken) begin
        pc_q <= redir_i.target;
      end else if (on_bus && !wait_q) begin
        pc_q <= pc_q + `CPU_XLEN'(4);  // advance once the port takes the fetch.
      end
      if (redir_i.taken) dec_valid_q <= 1'b0;
      else if (keep)     dec_valid_q <= 1'b1;
      else if (consume)  dec_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (on_bus && !wait_q) faddr_q <= pc_q;
    if (keep) begin
      dec_pc_q    <= fetch_addr;
      dec_instr_q <= rdata_i;
    end
  end

  assign dec_valid_o = dec_valid_q;
  assign dec_pc_o    = dec_pc_q;
  assign dec_instr_o = dec_instr_q;

endmodule

`default_nettype wire

// ==== rtl/mem_stage.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module mem_stage
  import cpu_pkg::*;
(
  input  wire                     clk_i,
  input  wire                     rst_i,
  input  wire exe_mem_t           mem_i,
  input  wire                     grant_i,
  input  wire                     rsp_valid_i,
  input  wire [`CPU_XLEN-1:0]     rdata_i,
  output mem_req_t                req_o,
  output logic                    stall_o,
  output logic                    wb_en_o,
  output logic [`CPU_RIDX_W-1:0]  wb_reg_o,
  output logic [`CPU_XLEN-1:0]    wb_data_o,
  output retire_t                 retire_o
);

  logic                    is_load;
  logic                    is_store;
  logic                    done;
  logic                    advance;

  logic                    wb_valid_q;
  logic                    wb_en_q;
  logic [`CPU_RIDX_W-1:0]  wb_rd_q;
  logic [`CPU_XLEN-1:0]    wb_data_q;
  logic [`CPU_XLEN-1:0]    wb_pc_q;

  assign is_load  = mem_i.valid & (mem_i.op == OP_LW);
  assign is_store = mem_i.valid & (mem_i.op == OP_SW);
  assign done     = (is_load | is_store) & grant_i & rsp_valid_i;
  assign stall_o  = (is_load | is_store) & ~done;  // hold upstream until the response.
  assign advance  = mem_i.valid & ~stall_o;

  // the request stays put since the stage register is frozen by stall.
  assign req_o = '{rd:       is_load,
                   wr:       is_store,
                   is_instr: 1'b0,
                   addr:     mem_i.result,
                   wdata:    mem_i.sdata};

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      wb_valid_q <= 1'b0;
      wb_en_q    <= 1'b0;
    end else begin
      wb_valid_q <= advance;
      wb_en_q    <= advance & mem_i.wr_en;
    end
  end

  always_ff @(posedge clk_i) begin
    if (advance) begin
      wb_rd_q   <= mem_i.rd;
      wb_data_q <= is_load ? rdata_i : mem_i.result;
      wb_pc_q   <= mem_i.pc;
    end
  end

  assign wb_en_o   = wb_en_q;
  assign wb_reg_o  = wb_rd_q;
  assign wb_data_o = wb_data_q;

  assign retire_o = '{valid: wb_valid_q,
                      pc:    wb_pc_q,
                      rd:    wb_rd_q,
                      wr_en: wb_en_q,
                      data:  wb_data_q};

endmodule

`default_nettype wire

// ==== rtl/rbank.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module rbank (
  input  wire                     clk_i,
  input  wire                     rst_i,
  input  wire                     wr_en_i,
  input  wire [`CPU_RIDX_W-1:0]   wr_reg_i,
  input  wire [`CPU_XLEN-1:0]     wr_data_i,
  input  wire [`CPU_RIDX_W-1:0]   rd_a_i,
  input  wire [`CPU_RIDX_W-1:0]   rd_b_i,
  output logic [`CPU_XLEN-1:0]    a_data_o,
  output logic [`CPU_XLEN-1:0]    b_data_o
);

  logic [`CPU_XLEN-1:0] regs_q [`CPU_NREGS];
  logic                 wr_live;

  assign wr_live = wr_en_i & (wr_reg_i != '0);  // r0 stays zero.

  always_ff @(posedge clk_i) begin
    if (!rst_i) begin
      for (int i = 0; i < `CPU_NREGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_live) begin
      regs_q[wr_reg_i] <= wr_data_i;
    end
  end

  // write-through so a read in the write cycle sees the new value.
  always_comb begin
    a_data_o = (wr_live && wr_reg_i == rd_a_i) ? wr_data_i : regs_q[rd_a_i];
    b_data_o = (wr_live && wr_reg_i == rd_b_i) ? wr_data_i : regs_q[rd_b_i];
  end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build with Verilator and run, result taken from the simulation output.
verilator --binary --timing --assert --top-module cpu_tb -f list.f -o cpu_sim \
  && ./obj_dir/cpu_sim | tee /dev/stderr | grep -F -q "** PASS **" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// ==== verif/cpu_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_properties
  import cpu_pkg::*;
(
  input wire            clk_i,
  input wire            rst_i,
  input wire mem_req_t  mem_req_o,
  input wire            mem_valid_i,
  input wire retire_t   retire_o
);

  // a port carries either a read or a write.
  a_rd_wr_excl: assert property (@(posedge clk_i) disable iff (!rst_i)
    !(mem_req_o.rd && mem_req_o.wr)) else $error("rd and wr high together");

  a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_i)
    ((mem_req_o.rd || mem_req_o.wr) && !mem_valid_i) |=> $stable(mem_req_o))
    else $error("memory request changed before its response");

  a_reset_idle: assert property (@(posedge clk_i)
    !rst_i |=> !(mem_req_o.rd || mem_req_o.wr) && !retire_o.valid)
    else $error("request or retire valid after reset");

endmodule

bind cpu cpu_properties u_props (
  .clk_i       (clk_i),
  .rst_i       (rst_i),
  .mem_req_o   (mem_req_o),
  .mem_valid_i (mem_valid_i),
  .retire_o    (retire_o)
);

`default_nettype wire

// ==== verif/cpu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "cpu_macros.svh"

module cpu_tb
  import cpu_pkg::*;
;

  logic                  clk_i;
  logic                  rst_i;
  logic                  mem_valid_i;
  logic [`CPU_XLEN-1:0]  mem_rdata_i;
  mem_req_t              mem_req;
  retire_t               retire;

  logic [`CPU_XLEN-1:0]  mem [1024];
  logic [`CPU_XLEN-1:0]  ref_mem [1024];
  instr_t                prog [$];
  retire_t               exp_retire [$];
  mem_req_t              exp_store [$];
  retire_t               got_seq [$];
  retire_t               first_seq [$];
  int                    errors = 0;
  int                    checked = 0;
  int                    cycles = 0;
  int                    limit = 0;
  int                    total;
  logic                  busy;
  int                    wait_cnt;

  cpu dut (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .mem_req_o   (mem_req),
    .mem_valid_i (mem_valid_i),
    .mem_rdata_i (mem_rdata_i),
    .retire_o    (retire)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycles++;
    if (limit > 0 && cycles > limit) begin
      $display("timeout: no progress within %0d cycles", limit);
      $display("** FAIL **");
      $finish;
    end
  end

  task automatic check_retire(input retire_t got, input retire_t exp);
    checked++;
    if (got.pc !== exp.pc || got.wr_en !== exp.wr_en) begin
      $display("[ERROR] retire_o.pc/wr_en: got %h/%h expected %h/%h",
               got.pc, got.wr_en, exp.pc, exp.wr_en);
      errors++;
    end else if (exp.wr_en && (got.rd !== exp.rd || got.data !== exp.data)) begin
      $display("[ERROR] retire_o.rd/data at pc %h: got %h/%h expected %h/%h",
               exp.pc, got.rd, got.data, exp.rd, exp.data);
      errors++;
    end
  endtask

  task automatic check_store(input mem_req_t got, input mem_req_t exp);
    if (got !== exp) begin
      $display("[ERROR] mem_req_o.rd/wr/is_instr/addr/wdata: got %h/%h/%h/%h/%h",
               got.rd, got.wr, got.is_instr, got.addr, got.wdata);
      $display("[ERROR] mem_req_o.rd/wr/is_instr/addr/wdata: expected %h/%h/%h/%h/%h",
               exp.rd, exp.wr, exp.is_instr, exp.addr, exp.wdata);
      errors++;
    end
  endtask

  // memory answers each request after 1 to 3 cycles.
  always @(negedge clk_i) begin
    if (!rst_i) begin
      busy = 1'b0;
      mem_valid_i <= 1'b0;
    end else if (mem_valid_i) begin
      mem_valid_i <= 1'b0;
      busy = 1'b0;
    end else if (busy || mem_req.rd || mem_req.wr) begin
      if (!busy) begin
        busy = 1'b1;
        wait_cnt = int'($urandom % 3);
      end
      if (wait_cnt == 0) begin
        if (mem_req.wr) begin
          if (exp_store.size() == 0) begin
            $display("unexpected store to address %h", mem_req.addr);
            errors++;
          end else begin
            check_store(mem_req, exp_store.pop_front());
          end
          mem[mem_req.addr[11:2]] = mem_req.wdata;
        end
        mem_rdata_i <= mem[mem_req.addr[11:2]];
        mem_valid_i <= 1'b1;
      end else begin
        wait_cnt--;
      end
    end
  end

  always @(negedge clk_i) begin
    if (rst_i && retire.valid && exp_retire.size() > 0) begin
      got_seq.push_back(retire);
      check_retire(retire, exp_retire.pop_front());
    end
  end

  function automatic instr_t mk(opcode_e op, int rd, int rs1, int rs2, int imm);
    instr_t i;
    i.op  = op;
    i.rd  = 4'(rd);
    i.rs1 = 4'(rs1);
    i.rs2 = 4'(rs2);
    i.imm = 14'(imm);
    return i;
  endfunction

  task automatic load_memory();
    for (int i = 0; i < 1024; i++) begin
      mem[i] = (32'(i) * 32'h9e37_79b1) ^ 32'(i);
    end
    foreach (prog[i]) mem[i] = prog[i];
    for (int i = 0; i < 1024; i++) ref_mem[i] = mem[i];
  endtask

  // ISA model: stops at the self jump that ends every program.
  task automatic run_model();
    logic [`CPU_XLEN-1:0] r [16];
    logic [`CPU_XLEN-1:0] pc;
    logic [`CPU_XLEN-1:0] npc;
    logic [`CPU_XLEN-1:0] imm;
    logic [`CPU_XLEN-1:0] a;
    logic [`CPU_XLEN-1:0] b;
    instr_t               in;
    retire_t              e;
    exp_retire.delete();
    exp_store.delete();
    for (int i = 0; i < 16; i++) r[i] = '0;
    pc = `CPU_RESET_PC;
    for (int step = 0; step < 200; step++) begin
      in = ref_mem[pc[11:2]];
      if (in.op == OP_JAL && in.imm == '0) break;
      imm = 32'(signed'(in.imm));
      a   = r[in.rs1];
      b   = r[in.rs2];
      npc = pc + 32'd4;
      e   = '{valid: 1'b1, pc: pc, rd: in.rd, wr_en: 1'b1, data: '0};
      case (in.op)
        OP_ADD:  e.data = a + b;
        OP_SUB:  e.data = a - b;
        OP_AND:  e.data = a & b;
        OP_OR:   e.data = a | b;
        OP_XOR:  e.data = a ^ b;
        OP_ADDI: e.data = a + imm;
        OP_LW:   e.data = ref_mem[(a + imm) >> 2];
        OP_JAL: begin
          e.data = pc + 32'd4;
          npc    = pc + (imm << 2);
        end
        default: e.wr_en = 1'b0;
      endcase
      if (in.op == OP_SW) begin
        ref_mem[(a + imm) >> 2] = b;
        exp_store.push_back(mem_req_t'{rd: 1'b0, wr: 1'b1, is_instr: 1'b0,
                                       addr: a + imm, wdata: b});
      end
      if ((in.op == OP_BEQ && a == b) || (in.op == OP_BNE && a != b)) npc = pc + (imm << 2);
      if (e.wr_en && in.rd != '0) r[in.rd] = e.data;
      exp_retire.push_back(e);
      pc = npc;
    end
  endtask

  task automatic run_prog(string name);
    @(negedge clk_i);
    rst_i <= 1'b0;
    @(negedge clk_i);
    load_memory();  // the previous program is held in reset from here on.
    run_model();
    got_seq.delete();
    repeat (2) @(negedge clk_i);
    rst_i <= 1'b1;
    while (exp_retire.size() > 0) @(negedge clk_i);
    if (exp_store.size() != 0) begin
      $display("%s: %0d stores never reached memory", name, exp_store.size());
      errors++;
    end
  endtask

  // r0 is read back well after its write has reached the register bank.
  task automatic alu_program();
    prog = '{mk(OP_ADDI, 1, 0, 0, 100), mk(OP_ADDI, 2, 0, 0, -7), mk(OP_ADDI, 0, 1, 0, 5),
             mk(OP_ADD, 3, 1, 2, 0), mk(OP_SUB, 4, 1, 2, 0), mk(OP_AND, 5, 1, 2, 0),
             mk(OP_OR, 6, 1, 2, 0), mk(OP_XOR, 7, 1, 2, 0), mk(OP_ADD, 8, 0, 0, 0),
             mk(OP_JAL, 0, 0, 0, 0)};
  endtask

  task automatic chain_program();
    prog = '{mk(OP_ADDI, 1, 0, 0, 1), mk(OP_ADD, 1, 1, 1, 0), mk(OP_ADD, 1, 1, 1, 0),
             mk(OP_SUB, 2, 1, 0, 0), mk(OP_ADD, 3, 2, 1, 0), mk(OP_XOR, 4, 3, 2, 0),
             mk(OP_JAL, 0, 0, 0, 0)};
  endtask

  task automatic store_load_program();
    prog = '{mk(OP_ADDI, 1, 0, 0, 2048), mk(OP_ADDI, 2, 0, 0, 1234), mk(OP_SW, 0, 1, 2, 4),
             mk(OP_LW, 3, 1, 0, 4), mk(OP_ADD, 4, 3, 3, 0), mk(OP_LW, 5, 1, 0, 8),
             mk(OP_SW, 0, 1, 4, 0), mk(OP_LW, 6, 1, 0, 0), mk(OP_JAL, 0, 0, 0, 0)};
  endtask

  task automatic branch_program();
    prog = '{mk(OP_ADDI, 1, 0, 0, 5), mk(OP_ADDI, 2, 0, 0, 5), mk(OP_BEQ, 0, 1, 2, 2),
             mk(OP_ADDI, 3, 0, 0, 99), mk(OP_BNE, 0, 1, 2, 3), mk(OP_ADDI, 4, 0, 0, 1),
             mk(OP_JAL, 5, 0, 0, 2), mk(OP_ADDI, 6, 0, 0, 77), mk(OP_ADDI, 7, 5, 0, 0),
             mk(OP_BEQ, 0, 1, 0, 2), mk(OP_BNE, 0, 1, 0, 2), mk(OP_ADDI, 8, 0, 0, 1),
             mk(OP_JAL, 0, 0, 0, 0)};
  endtask

  task automatic mixed_program();
    prog = '{mk(OP_ADDI, 1, 0, 0, 2048), mk(OP_ADDI, 2, 0, 0, 3), mk(OP_LW, 3, 1, 0, 0),
             mk(OP_ADD, 4, 4, 3, 0), mk(OP_SW, 0, 1, 4, 0), mk(OP_ADDI, 2, 2, 0, -1),
             mk(OP_BNE, 0, 2, 0, -4), mk(OP_XOR, 5, 4, 3, 0), mk(OP_JAL, 0, 0, 0, 0)};
  endtask

  task automatic test_alu();
    alu_program();
    run_prog("alu");
  endtask

  task automatic test_dependent();
    chain_program();
    run_prog("dependent");
  endtask

  task automatic test_store_load();
    store_load_program();
    run_prog("store/load");
  endtask

  task automatic test_branches();
    branch_program();
    run_prog("branches");
  endtask

  task automatic test_latency();
    mixed_program();
    run_prog("mixed first");
    first_seq = got_seq;
    run_prog("mixed second");
    if (got_seq.size() != first_seq.size()) begin
      $display("retire count changed between latency runs");
      errors++;
    end else begin
      foreach (got_seq[i]) check_retire(got_seq[i], first_seq[i]);
    end
  endtask

  initial begin
    rst_i       = 1'b0;
    mem_valid_i = 1'b0;
    mem_rdata_i = '0;
    busy        = 1'b0;
    wait_cnt    = 0;
    void'($urandom(32'h5f26_a5a2));
    alu_program();
    load_memory();
    run_model();
    total = exp_retire.size();
    chain_program();
    load_memory();
    run_model();
    total += exp_retire.size();
    store_load_program();
    load_memory();
    run_model();
    total += exp_retire.size();
    branch_program();
    load_memory();
    run_model();
    total += exp_retire.size();
    mixed_program();
    load_memory();
    run_model();
    total += 2 * exp_retire.size();  // run twice.
    limit = 20 * total;
    test_alu();
    test_dependent();
    test_store_load();
    test_branches();
    test_latency();
    $display("errors: %0d, retires checked: %0d", errors, checked);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire
